// File: hw/cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////////////////////////
    // sizes

    localparam int xlen      = 32;
    localparam int reg_count = 32;
    // depth of the memory model in words
    localparam int mem_words = 256;
    localparam logic [xlen-1:0] reset_pc = '0;

    //////////////////////////////////////////////////
    // rv32i major opcodes used by the subset

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // memory port commands
    localparam logic [1:0] mem_none  = 2'd0;
    localparam logic [1:0] mem_load  = 2'd1;
    localparam logic [1:0] mem_store = 2'd2;

    // commit error codes
    localparam logic [1:0] exc_none    = 2'd0;
    localparam logic [1:0] exc_halt    = 2'd1;
    localparam logic [1:0] exc_illegal = 2'd2;

    //////////////////////////////////////////////////
    // decoded operations, decode to execute

    localparam int xop_w = 4;
    localparam logic [xop_w-1:0] xop_add     = 4'd0;
    localparam logic [xop_w-1:0] xop_sub     = 4'd1;
    localparam logic [xop_w-1:0] xop_and     = 4'd2;
    localparam logic [xop_w-1:0] xop_or      = 4'd3;
    localparam logic [xop_w-1:0] xop_addi    = 4'd4;
    localparam logic [xop_w-1:0] xop_lw      = 4'd5;
    localparam logic [xop_w-1:0] xop_sw      = 4'd6;
    localparam logic [xop_w-1:0] xop_beq     = 4'd7;
    localparam logic [xop_w-1:0] xop_halt    = 4'd8;
    localparam logic [xop_w-1:0] xop_illegal = 4'd9;

    // one fetched word, three format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        // store and branch share this split
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } rv_inst_t;

endpackage

// File: hw/inst_fetch.sv
module inst_fetch import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            hold,
    input  logic            squash,
    input  logic            halted,
    input  logic [xlen-1:0] br_target,
    input  logic            if_done,
    input  logic [xlen-1:0] mem_rdata,
    output logic            if_req,
    output logic [xlen-1:0] if_addr,
    output logic            inst_valid,
    output rv_inst_t        inst_word,
    output logic [xlen-1:0] inst_pc
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] req_addr;
    // request raised and not yet answered
    logic            req_on;
    // answer belongs to a squashed path
    logic            drop;
    logic            accept;

    //////////////////////////////////////////////////
    // request side

    // an open request stays up, new ones wait out hold and squash
    assign if_req  = !halted && (req_on || (!hold && !squash));
    assign if_addr = req_on ? req_addr : pc;

    // word is kept only when decode can take it next edge
    assign accept = if_done && !drop && !squash && !halted && !hold;

    always_ff @(posedge clock) begin
        req_addr <= if_addr;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc     <= reset_pc;
            req_on <= 1'b0;
            drop   <= 1'b0;
        end else begin
            req_on <= if_req && !if_done;
            if (if_done) begin
                drop <= 1'b0;
            end else if (squash && req_on) begin
                drop <= 1'b1;
            end
            // redirect wins over fall-through
            if (squash) begin
                pc <= br_target;
            end else if (accept) begin
                pc <= pc + 32'd4;
            end
        end
    end

    //////////////////////////////////////////////////
    // fetch to decode register

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            inst_valid <= 1'b0;
        end else if (!hold) begin
            inst_valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            inst_word <= mem_rdata;
            inst_pc   <= req_addr;
        end
    end

endmodule

// File: hw/inst_decode.sv
module inst_decode import cpu_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             hold,
    input  logic             squash,
    input  logic             inst_valid,
    input  rv_inst_t         inst_word,
    input  logic [xlen-1:0]  inst_pc,
    output logic             ex_valid,
    output logic [xop_w-1:0] ex_op,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [xlen-1:0]  imm,
    output logic [xlen-1:0]  ex_pc
);

    logic [xop_w-1:0] dec_op;
    logic [xlen-1:0]  dec_imm;

    //////////////////////////////////////////////////
    // classify and build immediate

    always_comb begin
        dec_op  = xop_illegal;
        // i-format sign extension by default
        dec_imm = {{20{inst_word.i.imm[11]}}, inst_word.i.imm};
        case (inst_word.r.opcode)
            op_reg: begin
                case ({inst_word.r.funct7, inst_word.r.funct3})
                    10'b0000000_000: dec_op = xop_add;
                    10'b0100000_000: dec_op = xop_sub;
                    10'b0000000_111: dec_op = xop_and;
                    10'b0000000_110: dec_op = xop_or;
                    default:         dec_op = xop_illegal;
                endcase
            end
            op_imm:  dec_op = (inst_word.i.funct3 == 3'b000) ? xop_addi : xop_illegal;
            op_load: dec_op = (inst_word.i.funct3 == 3'b010) ? xop_lw : xop_illegal;
            op_store: begin
                dec_op  = (inst_word.s.funct3 == 3'b010) ? xop_sw : xop_illegal;
                dec_imm = {{20{inst_word.s.imm_hi[6]}}, inst_word.s.imm_hi,
                           inst_word.s.imm_lo};
            end
            op_branch: begin
                dec_op  = (inst_word.s.funct3 == 3'b000) ? xop_beq : xop_illegal;
                // b-format bits scattered over the s view
                dec_imm = {{20{inst_word.s.imm_hi[6]}}, inst_word.s.imm_lo[0],
                           inst_word.s.imm_hi[5:0], inst_word.s.imm_lo[4:1], 1'b0};
            end
            // only ecall, everything else in system space is illegal
            op_system: dec_op = (inst_word == 32'h0000_0073) ? xop_halt : xop_illegal;
            default:   dec_op = xop_illegal;
        endcase
    end

    //////////////////////////////////////////////////
    // decode to execute register

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            ex_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid <= inst_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!hold) begin
            ex_op <= dec_op;
            rd    <= inst_word.r.rd;
            rs1   <= inst_word.r.rs1;
            rs2   <= inst_word.s.rs2;
            imm   <= dec_imm;
            ex_pc <= inst_pc;
        end
    end

endmodule

// File: hw/exec_unit.sv
module exec_unit import cpu_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             ex_valid,
    input  logic [xop_w-1:0] ex_op,
    input  logic [4:0]       rd,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [xlen-1:0]  imm,
    input  logic [xlen-1:0]  ex_pc,
    input  logic             dm_done,
    input  logic [xlen-1:0]  mem_rdata,
    output logic [1:0]       dm_cmd,
    output logic [xlen-1:0]  dm_addr,
    output logic [xlen-1:0]  dm_wdata,
    output logic             ex_busy,
    output logic             br_taken,
    output logic [xlen-1:0]  br_target,
    output logic             commit_halt,
    output logic             commit_en,
    output logic             commit_wr_en,
    output logic [4:0]       commit_wr_idx,
    output logic [xlen-1:0]  commit_wr_data,
    output logic [xlen-1:0]  commit_npc,
    output logic [1:0]       commit_exc
);

    logic [xlen-1:0] regs [reg_count];
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] alu_out;
    logic            is_mem;
    logic            writes;

    //////////////////////////////////////////////////
    // operand read, x0 reads as zero

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // addi, lw and sw all add the immediate
    always_comb begin
        case (ex_op)
            xop_add: alu_out = rs1_val + rs2_val;
            xop_sub: alu_out = rs1_val - rs2_val;
            xop_and: alu_out = rs1_val & rs2_val;
            xop_or:  alu_out = rs1_val | rs2_val;
            default: alu_out = rs1_val + imm;
        endcase
    end

    //////////////////////////////////////////////////
    // loads and stores, one word at a time

    assign is_mem   = ex_valid && (ex_op == xop_lw || ex_op == xop_sw);
    assign dm_cmd   = !is_mem ? mem_none : (ex_op == xop_lw) ? mem_load : mem_store;
    assign dm_addr  = alu_out;
    assign dm_wdata = rs2_val;
    // stall upstream until the memory answers
    assign ex_busy  = is_mem && !dm_done;

    // beq against fall-through
    assign br_taken  = ex_valid && ex_op == xop_beq && rs1_val == rs2_val;
    assign br_target = ex_pc + imm;

    //////////////////////////////////////////////////
    // commit

    assign writes = ex_op inside {xop_add, xop_sub, xop_and, xop_or, xop_addi, xop_lw};

    assign commit_en      = ex_valid && (!is_mem || dm_done);
    assign commit_wr_en   = commit_en && writes && rd != 5'd0;
    assign commit_wr_idx  = rd;
    assign commit_wr_data = (ex_op == xop_lw) ? mem_rdata : alu_out;
    assign commit_npc     = br_taken ? br_target : ex_pc + 32'd4;
    assign commit_exc     = (ex_op == xop_halt)    ? exc_halt :
                            (ex_op == xop_illegal) ? exc_illegal : exc_none;
    assign commit_halt    = commit_en && commit_exc != exc_none;

    // cleared so a reset in place starts from zeroed registers
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_wr_en) begin
            regs[rd] <= commit_wr_data;
        end
    end

endmodule

// File: hw/mem_port.sv
module mem_port import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            if_req,
    input  logic [xlen-1:0] if_addr,
    input  logic [1:0]      dm_cmd,
    input  logic [xlen-1:0] dm_addr,
    input  logic [xlen-1:0] dm_wdata,
    input  logic            mem2proc_valid,
    input  logic [xlen-1:0] mem2proc_data,
    output logic [1:0]      proc2mem_command,
    output logic [xlen-1:0] proc2mem_addr,
    output logic [xlen-1:0] proc2mem_data,
    output logic            if_done,
    output logic            dm_done,
    output logic [xlen-1:0] mem_rdata
);

    logic idle;
    // granted request came from execute
    logic owner_dm;
    logic dm_wants;

    assign idle     = proc2mem_command == mem_none;
    assign dm_wants = dm_cmd != mem_none;

    //////////////////////////////////////////////////
    // grant, data side first

    // command held until the valid pulse, then port goes idle a cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            proc2mem_command <= mem_none;
            owner_dm         <= 1'b0;
        end else if (!idle) begin
            if (mem2proc_valid) begin
                proc2mem_command <= mem_none;
            end
        end else if (dm_wants) begin
            proc2mem_command <= dm_cmd;
            owner_dm         <= 1'b1;
        end else if (if_req) begin
            proc2mem_command <= mem_load;
            owner_dm         <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (idle) begin
            proc2mem_addr <= dm_wants ? dm_addr : if_addr;
            proc2mem_data <= dm_wdata;
        end
    end

    //////////////////////////////////////////////////
    // route the pulse back to its owner

    assign dm_done   = mem2proc_valid && !idle && owner_dm;
    assign if_done   = mem2proc_valid && !idle && !owner_dm;
    assign mem_rdata = mem2proc_data;

endmodule

// File: hw/pipe_control.sv
module pipe_control (
    input  logic clock,
    input  logic rst_n,
    input  logic ex_busy,
    input  logic br_taken,
    input  logic commit_halt,
    output logic hold,
    output logic squash,
    output logic halted
);

    logic halt_q;

    //////////////////////////////////////////////////
    // sticky halt

    // set by ecall or illegal commit, only reset clears it
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (commit_halt) begin
            halt_q <= 1'b1;
        end
    end

    // covers the commit cycle too, so no fetch starts there
    assign halted = halt_q || commit_halt;

    //////////////////////////////////////////////////
    // stall and flush

    // younger instructions behind a halt are flushed like a taken branch
    assign squash = br_taken || commit_halt;
    // squash beats hold
    assign hold   = ex_busy && !squash;

endmodule

// File: hw/cpu.sv
module cpu import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            mem2proc_valid,
    input  logic [xlen-1:0] mem2proc_data,
    output logic [1:0]      proc2mem_command,
    output logic [xlen-1:0] proc2mem_addr,
    output logic [xlen-1:0] proc2mem_data,
    output logic [3:0]      pipeline_completed_insts,
    output logic [1:0]      pipeline_error_status,
    output logic            pipeline_commit_wr_en,
    output logic [4:0]      pipeline_commit_wr_idx,
    output logic [xlen-1:0] pipeline_commit_wr_data,
    output logic [xlen-1:0] pipeline_commit_npc
);

    //////////////////////////////////////////////////
    // pipeline wires

    // control
    logic             hold;
    logic             squash;
    logic             halted;
    logic             ex_busy;
    logic             br_taken;
    logic [xlen-1:0]  br_target;
    logic             commit_halt;
    logic             commit_en;

    // fetch to decode
    logic             inst_valid;
    rv_inst_t         inst_word;
    logic [xlen-1:0]  inst_pc;

    // decode to execute
    logic             ex_valid;
    logic [xop_w-1:0] ex_op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [xlen-1:0]  imm;
    logic [xlen-1:0]  ex_pc;

    // requests into the shared port
    logic             if_req;
    logic [xlen-1:0]  if_addr;
    logic             if_done;
    logic [1:0]       dm_cmd;
    logic [xlen-1:0]  dm_addr;
    logic [xlen-1:0]  dm_wdata;
    logic             dm_done;
    logic [xlen-1:0]  mem_rdata;

    //////////////////////////////////////////////////
    // stages

    inst_fetch fetch (
        .clock(clock), .rst_n(rst_n),
        .hold(hold), .squash(squash), .halted(halted), .br_target(br_target),
        .if_done(if_done), .mem_rdata(mem_rdata),
        .if_req(if_req), .if_addr(if_addr),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_pc(inst_pc)
    );

    inst_decode decode (
        .clock(clock), .rst_n(rst_n), .hold(hold), .squash(squash),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_pc(inst_pc),
        .ex_valid(ex_valid), .ex_op(ex_op), .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .ex_pc(ex_pc)
    );

    // commit signals go straight out as the pipeline outputs
    exec_unit execute (
        .clock(clock), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_op(ex_op), .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .ex_pc(ex_pc),
        .dm_done(dm_done), .mem_rdata(mem_rdata),
        .dm_cmd(dm_cmd), .dm_addr(dm_addr), .dm_wdata(dm_wdata),
        .ex_busy(ex_busy), .br_taken(br_taken), .br_target(br_target),
        .commit_halt(commit_halt), .commit_en(commit_en),
        .commit_wr_en(pipeline_commit_wr_en),
        .commit_wr_idx(pipeline_commit_wr_idx),
        .commit_wr_data(pipeline_commit_wr_data),
        .commit_npc(pipeline_commit_npc),
        .commit_exc(pipeline_error_status)
    );

    mem_port port (
        .clock(clock), .rst_n(rst_n),
        .if_req(if_req), .if_addr(if_addr),
        .dm_cmd(dm_cmd), .dm_addr(dm_addr), .dm_wdata(dm_wdata),
        .mem2proc_valid(mem2proc_valid), .mem2proc_data(mem2proc_data),
        .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
        .proc2mem_data(proc2mem_data),
        .if_done(if_done), .dm_done(dm_done), .mem_rdata(mem_rdata)
    );

    pipe_control control (
        .clock(clock), .rst_n(rst_n),
        .ex_busy(ex_busy), .br_taken(br_taken), .commit_halt(commit_halt),
        .hold(hold), .squash(squash), .halted(halted)
    );

    // at most one retire per cycle
    assign pipeline_completed_insts = {3'b000, commit_en};

endmodule

// File: test/cpu_chk.sv
module cpu_chk import cpu_pkg::*; (
    input logic            clock,
    input logic            rst_n,
    input logic            mem2proc_valid,
    input logic [1:0]      proc2mem_command,
    input logic [xlen-1:0] proc2mem_addr,
    input logic [3:0]      pipeline_completed_insts,
    input logic            pipeline_commit_wr_en,
    input logic [4:0]      pipeline_commit_wr_idx,
    input logic            inst_valid,
    input logic            ex_valid
);

    //////////////////////////////////////////////////
    // memory port, command held until the pulse

    cmd_held: assert property (@(posedge clock) disable iff (!rst_n)
        (proc2mem_command != mem_none && !mem2proc_valid)
            |=> ($stable(proc2mem_command) && $stable(proc2mem_addr)))
        else $error("memory command or address changed before the valid pulse");

    //////////////////////////////////////////////////
    // commit outputs

    // x0 is never a destination
    no_x0_write: assert property (@(posedge clock) disable iff (!rst_n)
        pipeline_commit_wr_en |-> pipeline_commit_wr_idx != 5'd0)
        else $error("register write committed to x0");

    // empty pipe and idle port need two edges before anything retires
    quiet_when_empty: assert property (@(posedge clock) disable iff (!rst_n)
        (proc2mem_command == mem_none && !inst_valid && !ex_valid)
            |=> (pipeline_completed_insts == 4'd0 ##1 pipeline_completed_insts == 4'd0))
        else $error("commit with an empty pipeline");

endmodule

bind cpu cpu_chk chk (
    .clock(clock), .rst_n(rst_n), .mem2proc_valid(mem2proc_valid),
    .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
    .pipeline_completed_insts(pipeline_completed_insts),
    .pipeline_commit_wr_en(pipeline_commit_wr_en),
    .pipeline_commit_wr_idx(pipeline_commit_wr_idx),
    .inst_valid(inst_valid), .ex_valid(ex_valid)
);

// File: test/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

    // two runs, each 48 instructions of up to 3 requests of 5 cycles
    localparam int cycle_limit = 2 * 48 * 3 * 5 + 200;

    logic            clock;
    logic            rst_n;
    logic            mem2proc_valid;
    logic [xlen-1:0] mem2proc_data;
    logic [1:0]      proc2mem_command;
    logic [xlen-1:0] proc2mem_addr;
    logic [xlen-1:0] proc2mem_data;
    logic [3:0]      pipeline_completed_insts;
    logic [1:0]      pipeline_error_status;
    logic            pipeline_commit_wr_en;
    logic [4:0]      pipeline_commit_wr_idx;
    logic [xlen-1:0] pipeline_commit_wr_data;
    logic [xlen-1:0] pipeline_commit_npc;

    logic [31:0] seed;
    logic [31:0] image [mem_words];
    logic [31:0] mem [mem_words];
    logic [31:0] mdl [mem_words];
    // expected commit list from the ISA model
    logic        e_wr [64];
    logic [4:0]  e_idx [64];
    logic [31:0] e_data [64];
    logic [31:0] e_npc [64];
    logic [1:0]  e_exc [64];
    logic [31:0] e_pc [64];
    int n_exp, got, errors, checks, cycles, mem_wait;
    logic halt_seen, mem_busy;
    logic [1:0] prev_cmd;

    cpu uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    //////////////////////////////////////////////////
    // random program

    task automatic make_program();
        logic [31:0] x;
        logic [4:0]  rd, ra, rb;
        logic [11:0] off;
        logic [12:0] br;
        int k;
        for (int i = 0; i < mem_words; i++) begin
            image[i] = (i * 32'h9e3779b9) ^ 32'h1357_2468;
        end
        for (int w = 47; w < 64; w++) begin
            image[w] = 32'h0000_0073;
        end
        for (int w = 0; w < 47; w++) begin
            x   = rand_next();
            rd  = {2'b00, x[18:16]};
            ra  = {2'b00, x[21:19]};
            rb  = {2'b00, x[24:22]};
            x   = rand_next();
            off = {3'b001, x[22:16], 2'b00};
            case (x[30:28])
                3'd0, 3'd1: begin
                    case (x[27:26])
                        2'd0: image[w] = {7'b0000000, rb, ra, 3'b000, rd, op_reg};
                        2'd1: image[w] = {7'b0100000, rb, ra, 3'b000, rd, op_reg};
                        2'd2: image[w] = {7'b0000000, rb, ra, 3'b111, rd, op_reg};
                        default: image[w] = {7'b0000000, rb, ra, 3'b110, rd, op_reg};
                    endcase
                end
                3'd4: image[w] = {off, 5'd0, 3'b010, rd, op_load};
                3'd5: image[w] = {off[11:5], rb, 5'd0, 3'b010, off[4:0], op_store};
                3'd6, 3'd7: begin
                    // forward only, never past the final ecall
                    k = 1 + x[17:16];
                    if (w + k > 47) k = 47 - w;
                    br = 13'(k * 4);
                    if (x[20]) rb = ra;
                    image[w] = {br[12], br[10:5], rb, ra, 3'b000, br[4:1], br[11], op_branch};
                end
                default: image[w] = {x[27:16], ra, 3'b000, rd, op_imm};
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // ISA model, sequential

    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] pc, a, b, imm_i, imm_s, imm_b;
        rv_inst_t iw;
        logic done;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < mem_words; i++) mdl[i] = image[i];
        pc = reset_pc;
        n_exp = 0;
        done = 1'b0;
        while (!done && n_exp < 64) begin
            iw    = mdl[pc[9:2]];
            a     = r[iw.r.rs1];
            b     = r[iw.r.rs2];
            imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};
            imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
            imm_b = {{19{iw.s.imm_hi[6]}}, iw.s.imm_hi[6], iw.s.imm_lo[0],
                     iw.s.imm_hi[5:0], iw.s.imm_lo[4:1], 1'b0};
            e_pc[n_exp]  = pc;
            e_wr[n_exp]  = 1'b0;
            e_idx[n_exp] = iw.r.rd;
            e_npc[n_exp] = pc + 32'd4;
            e_exc[n_exp] = exc_none;
            e_data[n_exp] = '0;
            case ({iw.r.opcode, iw.r.funct3})
                {op_reg, 3'b000}: begin
                    e_wr[n_exp] = iw.r.funct7 inside {7'h00, 7'h20};
                    e_data[n_exp] = iw.r.funct7[5] ? a - b : a + b;
                end
                {op_reg, 3'b111}: begin
                    e_wr[n_exp] = iw.r.funct7 == 7'h00;
                    e_data[n_exp] = a & b;
                end
                {op_reg, 3'b110}: begin
                    e_wr[n_exp] = iw.r.funct7 == 7'h00;
                    e_data[n_exp] = a | b;
                end
                {op_imm, 3'b000}: begin
                    e_wr[n_exp] = 1'b1;
                    e_data[n_exp] = a + imm_i;
                end
                {op_load, 3'b010}: begin
                    e_wr[n_exp] = 1'b1;
                    e_data[n_exp] = mdl[((a + imm_i) >> 2) & 32'hff];
                end
                {op_store, 3'b010}: mdl[(a + imm_s) >> 2 & 32'hff] = b;
                {op_branch, 3'b000}: if (a == b) e_npc[n_exp] = pc + imm_b;
                default: begin
                    e_exc[n_exp] = (iw == 32'h0000_0073) ? exc_halt : exc_illegal;
                    done = 1'b1;
                end
            endcase
            // unsupported funct7 under op_reg
            if (iw.r.opcode == op_reg && !e_wr[n_exp]) begin
                e_exc[n_exp] = exc_illegal;
                done = 1'b1;
            end
            if (e_wr[n_exp] && iw.r.rd == 5'd0) e_wr[n_exp] = 1'b0;
            if (e_wr[n_exp]) r[iw.r.rd] = e_data[n_exp];
            pc = e_npc[n_exp];
            n_exp++;
        end
    endtask

    //////////////////////////////////////////////////
    // compare tasks

    task automatic check_commit(input logic wr_en, input logic [4:0] idx,
                                input logic [xlen-1:0] data, input logic [xlen-1:0] npc);
        checks++;
        if (pipeline_commit_wr_en !== wr_en) begin
            errors++;
            $display("error %0t pipeline_commit_wr_en got %0b expected %0b",
                     $time, pipeline_commit_wr_en, wr_en);
        end
        if (wr_en && (pipeline_commit_wr_idx !== idx || pipeline_commit_wr_data !== data)) begin
            errors++;
            $display("error %0t pipeline_commit_wr_idx/data got x%0d=%h expected x%0d=%h",
                     $time, pipeline_commit_wr_idx, pipeline_commit_wr_data, idx, data);
        end
        if (pipeline_commit_npc !== npc) begin
            errors++;
            $display("error %0t pipeline_commit_npc got %h expected %h",
                     $time, pipeline_commit_npc, npc);
        end
    endtask

    task automatic check_exc(input logic [1:0] exc);
        checks++;
        if (pipeline_error_status !== exc) begin
            errors++;
            $display("error %0t pipeline_error_status got %0d expected %0d",
                     $time, pipeline_error_status, exc);
        end
    endtask

    // memory word left behind by proc2mem_data stores
    task automatic check_mem(input int addr, input logic [xlen-1:0] word);
        checks++;
        if (mem[addr] !== word) begin
            errors++;
            $display("error %0t proc2mem_data at word %0d got %h expected %h",
                     $time, addr, mem[addr], word);
        end
    endtask

    //////////////////////////////////////////////////
    // memory model, random latency 1 to 4

    always @(negedge clock) begin
        logic [31:0] x;
        if (!rst_n) begin
            mem_busy = 1'b0;
            mem2proc_valid <= 1'b0;
        end else begin
            mem2proc_valid <= 1'b0;
            if (mem_busy) begin
                if (mem_wait == 1) begin
                    mem_busy = 1'b0;
                    mem2proc_valid <= 1'b1;
                    mem2proc_data  <= mem[proc2mem_addr[9:2]];
                    if (proc2mem_command == mem_store) mem[proc2mem_addr[9:2]] = proc2mem_data;
                end else begin
                    mem_wait--;
                end
            end else if (proc2mem_command != mem_none) begin
                x = rand_next();
                mem_busy = 1'b1;
                mem_wait = 1 + x[17:16];
            end
        end
    end

    //////////////////////////////////////////////////
    // commit monitor and run limit

    always @(posedge clock) begin
        if (rst_n) begin
            if (halt_seen && prev_cmd == mem_none && proc2mem_command != mem_none) begin
                errors++;
                $display("a memory request was issued after the halt at %0t", $time);
            end
            if (pipeline_completed_insts != 4'd0) begin
                if (halt_seen || got >= n_exp) begin
                    errors++;
                    $display("an instruction committed after the end of the program at %0t",
                             $time);
                end else begin
                    check_commit(e_wr[got], e_idx[got], e_data[got], e_npc[got]);
                    check_exc(e_exc[got]);
                    if (pipeline_error_status != exc_none) halt_seen = 1'b1;
                    got++;
                end
            end
            prev_cmd = proc2mem_command;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic run_program();
        run_model();
        for (int i = 0; i < mem_words; i++) mem[i] = image[i];
        @(negedge clock);
        rst_n = 1'b0;
        got = 0;
        halt_seen = 1'b0;
        prev_cmd = mem_none;
        repeat (4) @(negedge clock);
        rst_n = 1'b1;
        wait (halt_seen);
        // quiet period after the halt
        repeat (20) @(negedge clock);
        if (got != n_exp) begin
            errors++;
            $display("%0d instructions committed, the model expects %0d", got, n_exp);
        end
        for (int i = 0; i < mem_words; i++) begin
            check_mem(i, mdl[i]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        mem2proc_valid = 1'b0;
        mem2proc_data = '0;
        seed = 32'h6d576502;
        errors = 0;
        checks = 0;
        cycles = 0;
        n_exp = 0;
        make_program();
        run_program();
        // second run, an executed instruction becomes illegal
        image[e_pc[n_exp / 2] >> 2] = 32'h0000_007f;
        run_program();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
hw/cpu_pkg.sv
hw/inst_fetch.sv
hw/inst_decode.sv
hw/exec_unit.sv
hw/mem_port.sv
hw/pipe_control.sv
hw/cpu.sv
test/cpu_chk.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
